// File: hdl/psram_pkg.sv
package psram_pkg;

    localparam int ADDR_W = 23;         // Word address, 8M x 16
    localparam int DATA_W = 16;
    localparam int BE_W   = DATA_W / 8; // Upper and lower byte

    // BCR is selected by A[19:18] = 2'b10 during a CRE write
    localparam logic [1:0]  BCR_SEL   = 2'b10;
    // Bit 15 set selects async mode, drive strength and other fields at defaults
    localparam logic [15:0] BCR_FIELD = 16'h9D1F;

    localparam logic [ADDR_W-1:0] BCR_ASYNC = {3'b000, BCR_SEL, 2'b00, BCR_FIELD};

    // Controller FSM
    typedef enum logic [2:0] {
        CTRL_IDLE,
        CTRL_READ_WAIT,
        CTRL_READ_DATA,
        CTRL_WRITE_WAIT,
        CTRL_WRITE_DATA,
        CTRL_FINISH
    } ctrl_state_e;

    // Power-up sequencer FSM
    typedef enum logic [1:0] {
        INIT_POWERUP,     // Waiting out device start-up
        INIT_CFG_REQ,     // BCR write in flight
        INIT_CFG_RELEASE, // Request dropped, controller returns to idle
        INIT_READY
    } init_state_e;

endpackage

// File: hdl/mem_bus_if.sv
`timescale 1ns/100ps

interface mem_bus_if import psram_pkg::*; (
    input logic clk50MHz
);

    logic              req;
    logic              we;
    logic              cre;   // Configuration register access
    logic [BE_W-1:0]   be;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [DATA_W-1:0] rdata;
    logic              busy;
    logic              done;

    modport requester (output req, we, cre, be, addr, wdata, input rdata, busy, done);
    modport controller (input req, we, cre, be, addr, wdata, output rdata, busy, done);

    // Done is a single pulse and only answers a held request
    a_done_pulse: assert property (@(posedge clk50MHz) done |-> req ##1 !done);

    // Request fields may not move while the access is being counted out
    a_fields_stable: assert property (@(posedge clk50MHz)
        busy |=> req && $stable({we, cre, be, addr, wdata}));

endinterface

// File: hdl/psram_init.sv
`timescale 1ns/100ps

module psram_init import psram_pkg::*; #(
    parameter int POWERUP_CYCLES = 7500
) (
    input  logic              clk50MHz,
    input  logic              rst,
    input  logic              bus_req,
    input  logic              bus_we,
    input  logic [BE_W-1:0]   bus_be,
    input  logic [ADDR_W-1:0] bus_addr,
    input  logic [DATA_W-1:0] bus_wdata,
    output logic [DATA_W-1:0] bus_rdata,
    output logic              bus_wait,
    output logic              bus_done,
    output logic              init_done,
    mem_bus_if.requester      mbus
);

    localparam int PU_W = $clog2(POWERUP_CYCLES + 1);

    init_state_e     state;
    logic [PU_W-1:0] pu_cnt;  // Start-up delay counter
    logic            ready;

    always_ff @(posedge clk50MHz) begin
        if (rst) begin
            state  <= INIT_POWERUP;
            pu_cnt <= '0;
        end else begin
            case (state)
                INIT_POWERUP: begin
                    if (pu_cnt == PU_W'(POWERUP_CYCLES - 1)) begin
                        state <= INIT_CFG_REQ;
                    end else begin
                        pu_cnt <= pu_cnt + 1'b1;
                    end
                end
                INIT_CFG_REQ: begin
                    if (mbus.done) begin
                        state <= INIT_CFG_RELEASE;
                    end
                end
                // Controller leaves FINISH on this edge
                INIT_CFG_RELEASE: state <= INIT_READY;
                INIT_READY:       state <= INIT_READY;
                default:          state <= INIT_POWERUP;
            endcase
        end
    end

    assign ready     = (state == INIT_READY);
    assign init_done = ready;

    // Own the bus until the BCR write is done, then pass the requester through
    assign mbus.req   = ready ? bus_req   : (state == INIT_CFG_REQ);
    assign mbus.we    = ready ? bus_we    : 1'b1;
    assign mbus.cre   = !ready;
    assign mbus.be    = ready ? bus_be    : '0;
    assign mbus.addr  = ready ? bus_addr  : BCR_ASYNC;
    assign mbus.wdata = ready ? bus_wdata : '0;

    assign bus_rdata = mbus.rdata;
    assign bus_wait  = ready ? mbus.busy : 1'b1; // Held off during init
    assign bus_done  = ready && mbus.done;

    // Outside requester never sees an access complete before hand-over
    a_no_early_done: assert property (@(posedge clk50MHz) disable iff (rst)
        !init_done |-> !bus_done && bus_wait);

endmodule

// File: hdl/psram_async_ctrl.sv
`timescale 1ns/100ps

module psram_async_ctrl import psram_pkg::*; #(
    parameter int RW_LATENCY_CYCLES = 4
) (
    input  logic              clk50MHz,
    input  logic              rst,
    mem_bus_if.controller     mbus,
    output logic [ADDR_W-1:0] maddr,
    output logic              moe_l,
    output logic              mwe_l,
    output logic              madv_l,
    output logic              mce_l,
    output logic              mub_l,
    output logic              mlb_l,
    output logic              mcre,
    inout  wire  [DATA_W-1:0] mem_data
);

    localparam int CNT_W = $clog2(RW_LATENCY_CYCLES + 1);

    ctrl_state_e state;
    ctrl_state_e next_state;

    logic [CNT_W-1:0]  lat_cnt;   // Cycles spent in the wait state
    logic              last_wait;
    logic              in_wait;
    logic              in_write;
    logic              in_read;
    logic              drive_en;

    // Latched request
    logic              we_q;
    logic              cre_q;
    logic [BE_W-1:0]   be_q;
    logic [ADDR_W-1:0] addr_q;
    logic [DATA_W-1:0] wdata_q;
    logic [DATA_W-1:0] rdata_q;
    logic              done_q;

    assign in_wait   = (state == CTRL_READ_WAIT) || (state == CTRL_WRITE_WAIT);
    assign in_read   = (state == CTRL_READ_WAIT) || (state == CTRL_READ_DATA);
    assign in_write  = (state == CTRL_WRITE_WAIT) || (state == CTRL_WRITE_DATA);
    assign last_wait = in_wait && (lat_cnt == CNT_W'(RW_LATENCY_CYCLES - 1));

    always_ff @(posedge clk50MHz) begin
        if (rst) begin
            state <= CTRL_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            CTRL_IDLE: begin
                if (mbus.req) begin
                    next_state = mbus.we ? CTRL_WRITE_WAIT : CTRL_READ_WAIT;
                end
            end
            CTRL_READ_WAIT: begin
                if (last_wait) begin
                    next_state = CTRL_READ_DATA;
                end
            end
            CTRL_READ_DATA:  next_state = CTRL_FINISH;
            CTRL_WRITE_WAIT: begin
                if (last_wait) begin
                    next_state = CTRL_WRITE_DATA;
                end
            end
            CTRL_WRITE_DATA: next_state = CTRL_FINISH;
            CTRL_FINISH: begin
                if (!mbus.req) begin // Held request keeps us here
                    next_state = CTRL_IDLE;
                end
            end
            default:         next_state = CTRL_IDLE;
        endcase
    end

    // Latency counter, cleared outside the wait state
    always_ff @(posedge clk50MHz) begin
        if (rst || !in_wait) begin
            lat_cnt <= '0;
        end else begin
            lat_cnt <= lat_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk50MHz) begin
        if (state == CTRL_IDLE && mbus.req) begin
            we_q    <= mbus.we;
            cre_q   <= mbus.cre;
            be_q    <= mbus.be;
            addr_q  <= mbus.addr;
            wdata_q <= mbus.wdata;
        end
        if (state == CTRL_READ_DATA) begin
            rdata_q <= mem_data; // Sampled on the last edge of the data state
        end
    end

    always_ff @(posedge clk50MHz) begin
        if (rst) begin
            done_q <= 1'b0;
        end else begin
            done_q <= (state == CTRL_READ_DATA) || (state == CTRL_WRITE_DATA);
        end
    end

    // Pin strobes, all inactive in idle and finish
    always_comb begin
        moe_l  = 1'b1;
        mwe_l  = 1'b1;
        madv_l = 1'b1;
        mce_l  = 1'b1;
        mub_l  = 1'b1;
        mlb_l  = 1'b1;
        mcre   = 1'b0;
        if (in_read) begin
            mce_l  = 1'b0;
            madv_l = 1'b0;
            mub_l  = 1'b0; // Reads always return the full word
            mlb_l  = 1'b0;
            moe_l  = !(last_wait || state == CTRL_READ_DATA);
        end else if (in_write) begin
            mce_l  = 1'b0;
            madv_l = 1'b0;
            mcre   = cre_q;
            mub_l  = cre_q || !be_q[1];
            mlb_l  = cre_q || !be_q[0];
            // First wait cycle keeps WE high for tWPH
            mwe_l  = (state == CTRL_WRITE_WAIT) && (lat_cnt == '0);
        end
    end

    assign maddr = addr_q;

    // Data pins only carry write data, never during a CRE write
    assign drive_en = in_write && we_q && !cre_q && moe_l;
    assign mem_data = drive_en ? wdata_q : 'z;

    assign mbus.busy  = in_wait && !last_wait;
    assign mbus.done  = done_q;
    assign mbus.rdata = rdata_q;

    a_oe_we_excl: assert property (@(posedge clk50MHz) disable iff (rst)
        !(!moe_l && !mwe_l));

    a_idle_pins: assert property (@(posedge clk50MHz) disable iff (rst)
        (state == CTRL_IDLE) |-> mce_l && moe_l && mwe_l && !mcre);

    // No contention while the device drives, nor in the turnaround cycle
    a_bus_turnaround: assert property (@(posedge clk50MHz) disable iff (rst)
        !moe_l |-> !drive_en ##1 !drive_en);

endmodule

// File: hdl/psram_top.sv
`timescale 1ns/100ps

module psram_top import psram_pkg::*; #(
    parameter int RW_LATENCY_CYCLES = 4,    // 70 ns at 50 MHz
    parameter int POWERUP_CYCLES    = 7500  // 150 us start-up
) (
    input  logic              clk50MHz,
    input  logic              rst,
    input  logic              bus_req,
    input  logic              bus_we,
    input  logic [BE_W-1:0]   bus_be,
    input  logic [ADDR_W-1:0] bus_addr,
    input  logic [DATA_W-1:0] bus_wdata,
    output logic [DATA_W-1:0] bus_rdata,
    output logic              bus_wait,
    output logic              bus_done,
    output logic              init_done,
    output logic [ADDR_W-1:0] maddr,
    output logic              moe_l,
    output logic              mwe_l,
    output logic              madv_l,
    output logic              mce_l,
    output logic              mub_l,
    output logic              mlb_l,
    output logic              mcre,
    inout  wire  [DATA_W-1:0] mem_data
);

    mem_bus_if u_mbus (.clk50MHz(clk50MHz));

    psram_init #(
        .POWERUP_CYCLES(POWERUP_CYCLES)
    ) u_init (
        .clk50MHz  (clk50MHz),
        .rst       (rst),
        .bus_req   (bus_req),
        .bus_we    (bus_we),
        .bus_be    (bus_be),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bus_rdata (bus_rdata),
        .bus_wait  (bus_wait),
        .bus_done  (bus_done),
        .init_done (init_done),
        .mbus      (u_mbus.requester)
    );

    psram_async_ctrl #(
        .RW_LATENCY_CYCLES(RW_LATENCY_CYCLES)
    ) u_ctrl (
        .clk50MHz (clk50MHz),
        .rst      (rst),
        .mbus     (u_mbus.controller),
        .maddr    (maddr),
        .moe_l    (moe_l),
        .mwe_l    (mwe_l),
        .madv_l   (madv_l),
        .mce_l    (mce_l),
        .mub_l    (mub_l),
        .mlb_l    (mlb_l),
        .mcre     (mcre),
        .mem_data (mem_data)
    );

endmodule

// File: tb/psram_model.sv
`timescale 1ns/100ps

module psram_model import psram_pkg::*; (
    input  logic              clk50MHz,  // Pin sampling only
    input  logic [ADDR_W-1:0] maddr,
    input  logic              moe_l,
    input  logic              mwe_l,
    input  logic              madv_l,
    input  logic              mce_l,
    input  logic              mub_l,
    input  logic              mlb_l,
    input  logic              mcre,
    inout  wire  [DATA_W-1:0] mem_data,
    output logic [ADDR_W-1:0] bcr_value,
    output int                bcr_count
);

    logic [DATA_W-1:0] mem [logic [ADDR_W-1:0]];
    logic [DATA_W-1:0] rd_word;
    logic [DATA_W-1:0] word;
    logic              rd_en;
    logic              wr_pend;  // WE low seen, commit once it rises
    logic [ADDR_W-1:0] wr_addr;
    logic [DATA_W-1:0] wr_data;
    logic [1:0]        wr_be;
    logic              wr_cre;

    // Unwritten words read back as a pattern of their address
    function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] a);
        return a[15:0] ^ {a[22:16], a[22:14]};
    endfunction

    assign mem_data = rd_en ? rd_word : 'z;

    initial begin
        bcr_count = 0;
        bcr_value = '0;
        rd_en     = 1'b0;
        wr_pend   = 1'b0;
        forever begin
            @(negedge clk50MHz);
            rd_en   = !mce_l && !moe_l;
            rd_word = mem.exists(maddr) ? mem[maddr] : fill_word(maddr);
            if (!mce_l && !madv_l && !mwe_l) begin
                wr_pend = 1'b1;
                wr_addr = maddr;
                wr_data = mem_data;
                wr_be   = {!mub_l, !mlb_l};
                wr_cre  = mcre;
            end else if (wr_pend) begin
                wr_pend = 1'b0;
                if (wr_cre) begin  // Config write, value on the address pins
                    bcr_value = wr_addr;
                    bcr_count++;
                end else begin
                    word = mem.exists(wr_addr) ? mem[wr_addr] : fill_word(wr_addr);
                    if (wr_be[0]) word[7:0] = wr_data[7:0];
                    if (wr_be[1]) word[15:8] = wr_data[15:8];
                    mem[wr_addr] = word;
                end
            end
        end
    end

endmodule

// File: tb/psram_checker.sv
`timescale 1ns/100ps

module psram_checker import psram_pkg::*; #(
    parameter int RW_LATENCY_CYCLES = 4
) (
    input  logic              clk50MHz,
    input  logic              rst,
    input  logic              bus_req,
    input  logic              bus_we,
    input  logic [BE_W-1:0]   bus_be,
    input  logic [ADDR_W-1:0] bus_addr,
    input  logic [DATA_W-1:0] bus_wdata,
    input  logic [DATA_W-1:0] bus_rdata,
    input  logic              bus_wait,
    input  logic              bus_done,
    input  logic              init_done,
    input  logic              mce_l,
    input  logic [ADDR_W-1:0] bcr_value,
    input  int                bcr_count,
    output int                n_checks,
    output int                n_errors,
    output int                n_done
);

    logic [DATA_W-1:0] shadow [64];  // One word per window offset
    logic [5:0]        idx;
    logic              req_q;
    logic              init_q;
    logic              held;         // Done seen with the request still high
    int                cyc;
    int                start_cyc;

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        n_checks++;
        if (exp != act) begin
            n_errors++;
            $display("ERROR %0s: expected %0h, actual %0h", name, exp, act);
        end else begin
            $display("ok    %0s: %0h", name, act);
        end
    endtask

    task automatic report_failure(input string what);
        n_errors++;
        $display("Failure at cycle %0d: %0s", cyc, what);
    endtask

    // Sampled on the falling edge where all ports have settled
    initial begin
        n_checks  = 0;
        n_errors  = 0;
        n_done    = 0;
        req_q     = 1'b0;
        init_q    = 1'b0;
        held      = 1'b0;
        cyc       = 0;
        start_cyc = 0;
        forever begin
            @(negedge clk50MHz);
            cyc++;
            idx = bus_addr[5:0];
            if (rst) begin
                held = 1'b0;
            end else if (!init_done) begin
                if (bus_done || !bus_wait) begin
                    report_failure("bus_done high or bus_wait low during initialization");
                end
            end else begin
                if (!init_q) begin
                    compare_value("bcr_writes", 1, bcr_count);
                    compare_value("bcr_value", 32'(BCR_ASYNC), 32'(bcr_value));
                end
                if (bus_req && !req_q) start_cyc = cyc;  // Request first seen
                if (held && !mce_l) begin
                    report_failure("memory strobe while a finished request is held");
                end
                if (bus_done) begin
                    n_done++;
                    if (held) report_failure("second bus_done for one request");
                    compare_value("latency", RW_LATENCY_CYCLES + 2, cyc - start_cyc);
                    if (bus_we) begin
                        if (bus_be[0]) shadow[idx][7:0] = bus_wdata[7:0];
                        if (bus_be[1]) shadow[idx][15:8] = bus_wdata[15:8];
                    end else begin
                        compare_value("read", 32'(shadow[idx]), 32'(bus_rdata));
                    end
                    held = 1'b1;
                end
                if (!bus_req) held = 1'b0;
            end
            req_q  = bus_req;
            init_q = init_done;
        end
    end

endmodule

// File: tb/tb_psram_top.sv
`timescale 1ns/100ps

module tb_psram_top import psram_pkg::*; ();

    localparam int RW_LATENCY_CYCLES = 4;
    localparam int POWERUP_CYCLES    = 40;
    localparam int N_OPS             = 300;
    localparam int N_FILL            = 64;  // First pass writes the whole window
    localparam logic [ADDR_W-1:0] WIN_BASE = 23'h2A_5C40;
    localparam int TIMEOUT = POWERUP_CYCLES + N_OPS * (RW_LATENCY_CYCLES + 2 + 4) + 200;

    logic              clk50MHz = 1'b0;
    logic              rst;
    logic              bus_req;
    logic              bus_we;
    logic [BE_W-1:0]   bus_be;
    logic [ADDR_W-1:0] bus_addr;
    logic [DATA_W-1:0] bus_wdata;
    logic [DATA_W-1:0] bus_rdata;
    logic              bus_wait;
    logic              bus_done;
    logic              init_done;
    logic [ADDR_W-1:0] maddr;
    logic              moe_l;
    logic              mwe_l;
    logic              madv_l;
    logic              mce_l;
    logic              mub_l;
    logic              mlb_l;
    logic              mcre;
    wire  [DATA_W-1:0] mem_data;
    logic [ADDR_W-1:0] bcr_value;
    int                bcr_count;
    int                n_checks;
    int                n_errors;
    int                n_done;
    int                cycles = 0;
    logic [31:0]       seed = 32'h7c8a_5f89;

    always #10 clk50MHz = ~clk50MHz;

    psram_top #(
        .RW_LATENCY_CYCLES(RW_LATENCY_CYCLES),
        .POWERUP_CYCLES   (POWERUP_CYCLES)
    ) u_psram_top (.*);

    psram_model u_model (.*);

    psram_checker #(
        .RW_LATENCY_CYCLES(RW_LATENCY_CYCLES)
    ) u_checker (.*);

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic step();
        @(posedge clk50MHz);
        #2;
    endtask

    // One request held until done plus a few cycles of back-pressure
    task automatic do_access(input logic we, input logic [1:0] be, input logic [5:0] idx,
                             input logic [15:0] data, input int hold);
        bus_we    = we;
        bus_be    = be;
        bus_addr  = {WIN_BASE[ADDR_W-1:6], idx};
        bus_wdata = data;
        bus_req   = 1'b1;
        do step(); while (!bus_done);
        step();  // Request still high when done is sampled
        repeat (hold) step();
        bus_req = 1'b0;
        step();  // Controller leaves FINISH
    endtask

    always @(posedge clk50MHz) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT) begin
            $display("Run timed out after %0d cycles", cycles);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial begin
        logic [31:0] data_draw;
        rst       = 1'b1;
        bus_req   = 1'b0;
        bus_we    = 1'b0;
        bus_be    = '0;
        bus_addr  = WIN_BASE;
        bus_wdata = '0;
        repeat (10) @(posedge clk50MHz);
        #2;
        rst = 1'b0;
        do step(); while (!init_done);
        for (int i = 0; i < N_FILL; i++) begin
            seed = lcg_next(seed);
            do_access(1'b1, 2'b11, i[5:0], seed[31:16], 0);
        end
        for (int i = N_FILL; i < N_OPS; i++) begin
            seed      = lcg_next(seed);
            data_draw = lcg_next(seed);
            do_access(seed[30], seed[29] ? 2'b11 : seed[28:27], seed[26:21],
                      data_draw[31:16], seed[20] ? int'(seed[19:17]) % 6 : 0);
            seed = data_draw;
        end
        repeat (5) step();
        if (n_done != N_OPS) begin
            $display("ERROR access_count: expected %0d, actual %0d", N_OPS, n_done);
        end
        $display("%0d checks, %0d errors, %0d accesses", n_checks, n_errors, n_done);
        if (n_errors == 0 && n_done == N_OPS) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: sources.f
hdl/psram_pkg.sv
hdl/mem_bus_if.sv
hdl/psram_init.sv
hdl/psram_async_ctrl.sv
hdl/psram_top.sv
tb/psram_model.sv
tb/psram_checker.sv
tb/tb_psram_top.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module tb_psram_top
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_psram_top)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "STATUS: PASS"; then
    exit 0
fi
exit 1
